//--- verilog/cpu_settings.svh
// Assumes 8-bit data and 8-bit addresses with eight registers and eight I/O ports
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ----------------------------------------------------------
// Word and register file geometry
// ----------------------------------------------------------
`define CPU_DATA_W   8      // Data and address width
`define CPU_REG_CNT  8      // Register count, index 0 is A and 1 is B

// ----------------------------------------------------------
// Reset vector and I/O map
// ----------------------------------------------------------
// The first fetch reads from this address
`define CPU_RESET_PC 8'h00
`define CPU_IO_PORTS 8      // OUT reaches ports 0 to 7 only

`endif

//--- verilog/cpu_pkg.sv
// Shared CPU types; opcode layout is fixed to one byte with the class in bits 7:6
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0]          byte_t;   // Data or address word
  typedef logic [$clog2(`CPU_REG_CNT)-1:0] regid_t;  // Register index

  localparam regid_t REG_A = 3'd0;  // Accumulator and ALU destination
  localparam regid_t REG_B = 3'd1;  // Second ALU operand

  // ----------------------------------------------------------
  // Opcode encodings
  // ----------------------------------------------------------
  // Class 00 carries a group in bits 5:3 and a sub-field in bits 2:0
  localparam logic [1:0] CLS_CTRL = 2'b00;
  localparam logic [1:0] CLS_ALU  = 2'b01;  // 01_op_xxx
  localparam logic [1:0] CLS_MOV  = 2'b10;  // 10_src_dst
  localparam regid_t GRP_MISC = 3'b000;     // 00_000_000 is NOP
  localparam regid_t GRP_OUT  = 3'b001;     // Sub-field is the port
  localparam regid_t GRP_LDI  = 3'b010;     // Sub-field is the destination
  localparam regid_t GRP_JMP  = 3'b011;     // Sub-field is the condition
  localparam regid_t SUB_HLT  = 3'b101;
  localparam regid_t SUB_CMP  = 3'b110;

  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_INC = 3'b010,
    ALU_DEC = 3'b011,
    ALU_AND = 3'b100,
    ALU_OR  = 3'b101,
    ALU_XOR = 3'b110,
    ALU_ADC = 3'b111
  } alu_op_t;

  typedef enum logic [2:0] {
    JMP_JMP = 3'b000,
    JMP_JZ  = 3'b001,
    JMP_JNZ = 3'b010,
    JMP_JC  = 3'b011,  // Taken when A < B after CMP
    JMP_JNC = 3'b100
  } jmp_cond_t;

  // One opcode byte read two ways
  typedef union packed {
    struct packed {
      logic [1:0] cls;
      alu_op_t    op;
      regid_t     dst;  // Ignored, ALU results always go to A
    } alu_fmt;
    struct packed {
      logic [1:0] cls;
      regid_t     src;  // Group in class 00
      regid_t     dst;  // Sub-field in class 00
    } mov_fmt;
  } instr_u;

  typedef struct packed {
    logic zero;
    logic carry;  // Also the borrow of SUB, DEC and CMP
  } flags_t;

  typedef enum logic [2:0] {
    BUS_PC,
    BUS_ALU,
    BUS_REG,
    BUS_IMM,
    BUS_MEM
  } bus_src_t;

  typedef struct packed {
    byte_t addr;   // Memory address or I/O port
    byte_t wdata;
    logic  write;
    logic  io;
  } mem_cmd_t;

  typedef struct packed {
    logic     ir_load;
    logic     imm_load;
    logic     mar_load;
    logic     pc_inc;
    logic     pc_load;
    logic     rf_write;
    logic     alu_exec;
    bus_src_t bus_src;
    regid_t   rf_wsel;
    regid_t   rf_rsel;
  } ctrl_t;

  typedef enum logic [3:0] {
    ST_NEXT = 4'd0,  // Decode and point MAR past the opcode
    ST_FETCH_PC,
    ST_FETCH_INST,
    ST_FETCH_IMM,
    ST_LOAD_IMM,
    ST_MOV,
    ST_ALU_EXEC,
    ST_ALU_WB,
    ST_JUMP,
    ST_OUT,
    ST_HALT
  } state_t;

endpackage

//--- verilog/cpu_regfile.sv
// Register file clears to zero on reset; A and B are hard views for the ALU
`include "cpu_settings.svh"

module cpu_regfile (
  input  logic            clk,
  input  logic            reset,
  input  logic            write,
  input  cpu_pkg::regid_t wsel,
  input  cpu_pkg::regid_t rsel,
  input  cpu_pkg::byte_t  wdata,
  output cpu_pkg::byte_t  rdata,
  output cpu_pkg::byte_t  rega,
  output cpu_pkg::byte_t  regb
);
  import cpu_pkg::*;

  byte_t regs [`CPU_REG_CNT];  // Register 7 is ordinary storage

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[wsel] <= wdata;  // Visible on the read port next cycle
    end
  end

  // Read side
  assign rdata = regs[rsel];   // Bus source for MOV
  assign rega  = regs[REG_A];  // ALU in_a and OUT data
  assign regb  = regs[REG_B];

endmodule

//--- verilog/cpu_alu.sv
// ALU result and Zero/Carry flags register one cycle after exec and hold otherwise
module cpu_alu (
  input  logic             clk,
  input  logic             reset,
  input  logic             exec,
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::byte_t   in_a,
  input  cpu_pkg::byte_t   in_b,
  output cpu_pkg::byte_t   result,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  logic [8:0] calc;  // Bit 8 is carry out or borrow

  always_comb begin
    case (op)
      ALU_ADD: calc = {1'b0, in_a} + {1'b0, in_b};
      ALU_SUB: calc = {1'b0, in_a} - {1'b0, in_b};  // Borrow wraps into bit 8
      ALU_INC: calc = {1'b0, in_a} + 9'd1;
      ALU_DEC: calc = {1'b0, in_a} - 9'd1;
      ALU_AND: calc = {1'b0, in_a & in_b};
      ALU_OR:  calc = {1'b0, in_a | in_b};
      ALU_XOR: calc = {1'b0, in_a ^ in_b};
      ALU_ADC: calc = {1'b0, in_a} + {1'b0, in_b} + 9'(flags.carry);  // Stored carry
      default: calc = '0;
    endcase
  end

  // Result and flags update together
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      result <= '0;
      flags  <= '0;
    end else if (exec) begin
      result      <= calc[7:0];
      flags.zero  <= (calc[7:0] == 8'd0);
      flags.carry <= calc[8];  // Logic ops clear carry
    end
  end

  // The controller must hand over a resolved opcode when it fires the ALU
  a_op_known: assert property (@(posedge clk) disable iff (reset)
    exec |-> !$isunknown(op))
    else $error("ALU exec with undefined op");

endmodule

//--- verilog/cpu_datapath.sv
// Datapath with one internal bus mux; PC and MAR reset to the reset vector
`include "cpu_settings.svh"

module cpu_datapath (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::ctrl_t   ctrl,
  input  cpu_pkg::byte_t   mem_data,
  input  cpu_pkg::alu_op_t alu_op,
  output cpu_pkg::instr_u  instr,
  output cpu_pkg::flags_t  flags,
  output cpu_pkg::byte_t   mar,
  output cpu_pkg::byte_t   bus_a
);
  import cpu_pkg::*;

  byte_t pc;
  byte_t imm;         // Immediate or jump target
  byte_t bus;         // Internal bus
  byte_t rf_rdata;
  byte_t alu_result;
  byte_t regb;

  // ----------------------------------------------------------
  // Bus mux, one source per cycle
  // ----------------------------------------------------------
  always_comb begin
    case (ctrl.bus_src)
      BUS_PC:  bus = pc;
      BUS_ALU: bus = alu_result;
      BUS_REG: bus = rf_rdata;
      BUS_IMM: bus = imm;
      BUS_MEM: bus = mem_data;   // Held read byte from the memory port
      default: bus = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc    <= `CPU_RESET_PC;
      mar   <= `CPU_RESET_PC;  // First fetch needs no MAR load
      instr <= '0;             // NOP
    end else begin
      if (ctrl.pc_load) pc <= bus;                      // Taken jump
      else if (ctrl.pc_inc) pc <= pc + byte_t'(1);
      if (ctrl.mar_load) mar <= bus;
      if (ctrl.ir_load) instr <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.imm_load) imm <= bus;
  end

  cpu_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .write (ctrl.rf_write),
    .wsel  (ctrl.rf_wsel),
    .rsel  (ctrl.rf_rsel),
    .wdata (bus),
    .rdata (rf_rdata),
    .rega  (bus_a),   // A also feeds OUT
    .regb  (regb)
  );

  cpu_alu u_alu (
    .clk    (clk),
    .reset  (reset),
    .exec   (ctrl.alu_exec),
    .op     (alu_op),
    .in_a   (bus_a),
    .in_b   (regb),
    .result (alu_result),
    .flags  (flags)
  );

  // Microcode never asks for both PC updates in one state
  a_pc_excl: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.pc_inc && ctrl.pc_load))
    else $error("PC increment and load together");

endmodule

//--- verilog/cpu_ctrl.sv
// Microcode FSM; leaves reset in the first fetch and waits on xfer_done in every memory state
`include "cpu_settings.svh"

module cpu_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::instr_u   instr,
  input  cpu_pkg::flags_t   flags,
  input  logic              xfer_done,
  output cpu_pkg::ctrl_t    ctrl,
  output cpu_pkg::alu_op_t  alu_op,
  output logic              xfer_start,
  output cpu_pkg::mem_cmd_t xfer_cmd,
  output logic              halted,
  input  cpu_pkg::byte_t    mar,
  input  cpu_pkg::byte_t    bus_a
);
  import cpu_pkg::*;

  state_t state;
  state_t state_nxt;
  logic   xfer_busy;   // Request issued, waiting for done
  logic   mem_state;
  logic   is_cmp;
  logic   jmp_take;

  // ----------------------------------------------------------
  // Decode helpers
  // ----------------------------------------------------------
  assign is_cmp = (instr.mov_fmt.cls == CLS_CTRL) && (instr.mov_fmt.src == GRP_MISC) &&
                  (instr.mov_fmt.dst == SUB_CMP);
  assign alu_op = is_cmp ? ALU_SUB : instr.alu_fmt.op;  // CMP reuses SUB

  always_comb begin
    case (jmp_cond_t'(instr.mov_fmt.dst))
      JMP_JMP: jmp_take = 1'b1;
      JMP_JZ:  jmp_take = flags.zero;
      JMP_JNZ: jmp_take = !flags.zero;
      JMP_JC:  jmp_take = flags.carry;
      JMP_JNC: jmp_take = !flags.carry;
      default: jmp_take = 1'b0;   // Unused codes fall through
    endcase
  end

  // ----------------------------------------------------------
  // Transfer requests
  // ----------------------------------------------------------
  assign mem_state  = state inside {ST_FETCH_INST, ST_FETCH_IMM, ST_OUT};
  assign xfer_start = mem_state && !xfer_busy;  // One request per memory state

  always_comb begin
    xfer_cmd.addr  = mar;      // Reads come from MAR
    xfer_cmd.wdata = bus_a;
    xfer_cmd.write = 1'b0;
    xfer_cmd.io    = 1'b0;
    if (state == ST_OUT) begin
      xfer_cmd.addr  = byte_t'(instr.mov_fmt.dst) & byte_t'(`CPU_IO_PORTS - 1);
      xfer_cmd.write = 1'b1;
      xfer_cmd.io    = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Strobes and next state
  // ----------------------------------------------------------
  always_comb begin
    ctrl         = '0;
    ctrl.bus_src = BUS_PC;
    ctrl.rf_wsel = REG_A;
    ctrl.rf_rsel = instr.mov_fmt.src;
    state_nxt    = state;
    case (state)
      ST_NEXT: begin
        ctrl.mar_load = 1'b1;   // PC already past the opcode
        case (instr.mov_fmt.cls)
          CLS_ALU: state_nxt = ST_ALU_EXEC;
          CLS_MOV: state_nxt = ST_MOV;
          CLS_CTRL: begin
            case (instr.mov_fmt.src)
              GRP_LDI, GRP_JMP: state_nxt = ST_FETCH_IMM;
              GRP_OUT:          state_nxt = ST_OUT;
              GRP_MISC: begin
                if (instr.mov_fmt.dst == SUB_HLT) state_nxt = ST_HALT;
                else if (is_cmp) state_nxt = ST_ALU_EXEC;
                else state_nxt = ST_FETCH_INST;   // NOP
              end
              default: state_nxt = ST_FETCH_INST;
            endcase
          end
          default: state_nxt = ST_FETCH_INST;      // Class 11 acts as NOP
        endcase
      end
      ST_FETCH_PC: begin
        ctrl.mar_load = 1'b1;
        state_nxt     = ST_FETCH_INST;
      end
      ST_FETCH_INST: begin
        ctrl.bus_src = BUS_MEM;
        if (xfer_done) begin
          ctrl.ir_load = 1'b1;
          ctrl.pc_inc  = 1'b1;
          state_nxt    = ST_NEXT;
        end
      end
      ST_FETCH_IMM: begin
        ctrl.bus_src = BUS_MEM;
        if (xfer_done) begin
          ctrl.imm_load = 1'b1;
          ctrl.pc_inc   = 1'b1;   // Skip the operand byte
          state_nxt     = (instr.mov_fmt.src == GRP_JMP) ? ST_JUMP : ST_LOAD_IMM;
        end
      end
      ST_LOAD_IMM: begin
        ctrl.bus_src  = BUS_IMM;
        ctrl.rf_write = 1'b1;
        ctrl.rf_wsel  = instr.mov_fmt.dst;
        state_nxt     = ST_FETCH_PC;
      end
      ST_MOV: begin
        ctrl.bus_src  = BUS_REG;
        ctrl.rf_write = 1'b1;
        ctrl.rf_wsel  = instr.mov_fmt.dst;
        state_nxt     = ST_FETCH_PC;
      end
      ST_ALU_EXEC: begin
        ctrl.alu_exec = 1'b1;
        state_nxt     = is_cmp ? ST_FETCH_PC : ST_ALU_WB;  // CMP keeps A
      end
      ST_ALU_WB: begin
        ctrl.bus_src  = BUS_ALU;
        ctrl.rf_write = 1'b1;
        state_nxt     = ST_FETCH_PC;
      end
      ST_JUMP: begin
        ctrl.bus_src = BUS_IMM;
        ctrl.pc_load = jmp_take;
        state_nxt    = ST_FETCH_PC;
      end
      ST_OUT: if (xfer_done) state_nxt = ST_FETCH_PC;
      ST_HALT: state_nxt = ST_HALT;   // Only reset leaves
      default: state_nxt = ST_FETCH_PC;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= ST_FETCH_INST;   // MAR holds the reset vector
      xfer_busy <= 1'b0;
    end else begin
      state <= state_nxt;
      if (xfer_start) xfer_busy <= 1'b1;
      else if (xfer_done) xfer_busy <= 1'b0;
    end
  end

  assign halted = (state == ST_HALT);

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {ST_NEXT, ST_FETCH_PC, ST_FETCH_INST, ST_FETCH_IMM, ST_LOAD_IMM, ST_MOV,
                  ST_ALU_EXEC, ST_ALU_WB, ST_JUMP, ST_OUT, ST_HALT})
    else $error("Controller left the state set");

endmodule

//--- verilog/cpu_mem_port.sv
// Four-phase req/ack master; a new xfer_start is only honoured while idle
module cpu_mem_port (
  input  logic              clk,
  input  logic              reset,
  input  logic              xfer_start,
  input  cpu_pkg::mem_cmd_t xfer_cmd,
  output logic              xfer_done,
  output cpu_pkg::byte_t    xfer_rdata,
  output logic              mem_req,
  output cpu_pkg::mem_cmd_t mem_cmd,
  input  logic              mem_ack,
  input  cpu_pkg::byte_t    mem_rdata
);

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_REQ,   // req high, waiting for ack
    MP_REL    // req dropped, waiting for ack to fall
  } mp_state_t;

  mp_state_t state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= MP_IDLE;
      mem_req   <= 1'b0;
      xfer_done <= 1'b0;
    end else begin
      xfer_done <= 1'b0;   // Single-cycle pulse
      case (state)
        MP_IDLE: if (xfer_start) begin
          mem_req <= 1'b1;
          state   <= MP_REQ;
        end
        MP_REQ: if (mem_ack) begin
          mem_req <= 1'b0;
          state   <= MP_REL;
        end
        MP_REL: if (!mem_ack) begin
          xfer_done <= 1'b1;
          state     <= MP_IDLE;
        end
        default: state <= MP_IDLE;
      endcase
    end
  end

  // Command held for the whole handshake, read byte held until reused
  always_ff @(posedge clk) begin
    if (state == MP_IDLE && xfer_start) mem_cmd <= xfer_cmd;
    if (state == MP_REQ && mem_ack && !mem_cmd.write) xfer_rdata <= mem_rdata;
  end

  a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
    $past(mem_req) && mem_req |-> $stable(mem_cmd))
    else $error("mem_cmd changed during request");

  a_req_after_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(mem_req) |-> $past(mem_ack))
    else $error("mem_req dropped before mem_ack");

endmodule

//--- verilog/cpu.sv
// CPU top level; the responder must follow the four-phase req/ack rule on mem_req
module cpu (
  input  logic              clk,
  input  logic              reset,
  output logic              mem_req,
  output cpu_pkg::mem_cmd_t mem_cmd,
  input  logic              mem_ack,
  input  cpu_pkg::byte_t    mem_rdata,
  output logic              halted
);
  import cpu_pkg::*;

  ctrl_t    ctrl;        // Controller strobes
  alu_op_t  alu_op;
  instr_u   instr;
  flags_t   flags;
  byte_t    mar;
  byte_t    bus_a;       // Register A for OUT
  logic     xfer_start;
  logic     xfer_done;
  mem_cmd_t xfer_cmd;
  byte_t    xfer_rdata;

  cpu_datapath u_datapath (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .mem_data (xfer_rdata),
    .alu_op   (alu_op),
    .instr    (instr),
    .flags    (flags),
    .mar      (mar),
    .bus_a    (bus_a)
  );

  cpu_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .flags      (flags),
    .xfer_done  (xfer_done),
    .ctrl       (ctrl),
    .alu_op     (alu_op),
    .xfer_start (xfer_start),
    .xfer_cmd   (xfer_cmd),
    .halted     (halted),
    .mar        (mar),
    .bus_a      (bus_a)
  );

  cpu_mem_port u_mem_port (
    .clk        (clk),
    .reset      (reset),
    .xfer_start (xfer_start),
    .xfer_cmd   (xfer_cmd),
    .xfer_done  (xfer_done),
    .xfer_rdata (xfer_rdata),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

endmodule

//--- tb/tb_cpu.sv
// Run from the project root; memory is a flat 256-byte image read from tb/cpu_stim.txt
module tb_cpu;
  import cpu_pkg::*;

  typedef struct packed {
    byte_t port;
    byte_t data;
  } out_exp_t;                // One expected OUT write

  logic     clk;
  logic     reset;
  logic     mem_req;
  mem_cmd_t mem_cmd;
  logic     mem_ack;
  byte_t    mem_rdata;
  logic     halted;

  byte_t    mem [256];        // Program image
  out_exp_t exp_q [$];        // Expected OUTs, oldest first
  int       m_count;          // M lines read
  int       o_count;          // O lines read
  int       out_seen;
  int       val_errs;         // Wrong values
  int       fail_errs;        // Protocol and flow failures
  int       seed = 32'h557b_7b80;

  cpu uut (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // Period 40
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_port(input byte_t got, input byte_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: OUT port got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      val_errs++;
      $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Image fill, then M and O lines; anything else is a comment
  task automatic load_stim(output bit ok);
    int       fd;
    int       n;
    string    line;
    byte_t    a;
    byte_t    d;
    out_exp_t e;
    ok = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = byte_t'(i) ^ 8'hA5;   // Unlisted bytes
    end
    fd = $fopen("tb/cpu_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          if ($sscanf(line, "M %h %h", a, d) == 2) begin
            mem[a] = d;
            m_count++;
          end else if ($sscanf(line, "O %h %h", a, d) == 2) begin
            e.port = a;
            e.data = d;
            exp_q.push_back(e);
            o_count++;
          end
        end
      end
      $fclose(fd);
      ok = (m_count > 0);
    end
  endtask

  // Match one io write against the next expectation
  task automatic take_out(input mem_cmd_t cmd);
    out_exp_t e;
    out_seen++;
    if (exp_q.size() == 0) begin
      fail_errs++;
      $display("OUT to port %0d with data %02h came after all expected OUTs",
               cmd.addr, cmd.wdata);
    end else begin
      e = exp_q.pop_front();
      check_port(cmd.addr, e.port);
      check_byte(cmd.wdata, e.data, "OUT data");
    end
  endtask

  // ----------------------------------------------------------
  // Memory and I/O responder
  // ----------------------------------------------------------
  initial begin : responder
    int       delay;
    mem_cmd_t cmd;
    logic     first_req;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    first_req = 1'b1;
    forever begin
      @(negedge clk);
      if (!reset && mem_req) begin
        cmd   = mem_cmd;                // Held stable for the whole handshake
        delay = $random(seed) & 3;      // 0 to 3 cycles
        repeat (delay) @(negedge clk);
        if (first_req) begin
          check_byte(cmd.addr, 8'h00, "first fetch address");
          first_req = 1'b0;
        end
        if (!cmd.write) begin
          mem_rdata = mem[cmd.addr];    // Valid with the ack
        end else if (cmd.io) begin
          take_out(cmd);
        end else begin
          fail_errs++;
          $display("Memory write to address %02h, but the CPU has no store", cmd.addr);
        end
        mem_ack = 1'b1;
        while (mem_req) @(negedge clk); // Wait for req to drop
        mem_ack = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Reset, run to halt, closing checks
  // ----------------------------------------------------------
  initial begin : main
    bit ok;
    int limit;
    int cycles;
    reset     = 1'b1;
    m_count   = 0;
    o_count   = 0;
    out_seen  = 0;
    val_errs  = 0;
    fail_errs = 0;
    load_stim(ok);
    if (!ok) begin
      $display("Stimulus file tb/cpu_stim.txt is missing or holds no memory image");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      limit = m_count * 40;             // Generous per program byte
      repeat (16) begin
        @(negedge clk);
        if (mem_req || halted) begin
          fail_errs++;
          $display("mem_req or halted went high while reset was held");
        end
      end
      reset  = 1'b0;
      cycles = 0;
      while (!halted && cycles < limit) begin
        @(negedge clk);
        cycles++;
      end
      if (!halted) begin
        $display("The CPU never halted within %0d cycles", limit);
        $display("Value errors: %0d, other failures: %0d", val_errs, fail_errs);
        $display("ERRORS FOUND");
        $finish;
      end else begin
        check_count(out_seen, o_count, "OUT count at halt");
        repeat (20) begin               // Halt must be quiet and sticky
          @(negedge clk);
          if (mem_req) begin
            fail_errs++;
            $display("A memory request came after halt");
          end
          if (!halted) begin
            fail_errs++;
            $display("halted dropped without a reset");
          end
        end
        $display("Value errors: %0d, other failures: %0d", val_errs, fail_errs);
        if (val_errs == 0 && fail_errs == 0) begin
          $display("NO ERRORS");
        end else begin
          $display("ERRORS FOUND");
        end
        $finish;
      end
    end
  end

endmodule

//--- vlog.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_datapath.sv
verilog/cpu_ctrl.sv
verilog/cpu_mem_port.sv
verilog/cpu.sv
tb/tb_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it, and judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f vlog.f --top-module tb_cpu -o tb_cpu_sim

./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb/cpu_stim.txt
# M <addr> <byte>   program image, both hex
# O <port> <data>   expected OUT writes in order, both hex
M 00 10   # LDI A 3C
M 01 3C
M 02 11   # LDI B C5
M 03 C5
M 04 17   # LDI T 99
M 05 99
M 06 09   # OUT 1
M 07 BA   # MOV T to r2
M 08 90   # MOV r2 to A
M 09 0A   # OUT 2
M 0A 40   # ADD sets carry
M 0B 0B   # OUT 3
M 0C 78   # ADC uses that carry
M 0D 0C   # OUT 4
M 0E 50   # INC
M 0F 0D   # OUT 5
M 10 58   # DEC
M 11 0E   # OUT 6
M 12 48   # SUB with borrow
M 13 0F   # OUT 7
M 14 60   # AND
M 15 08   # OUT 0
M 16 68   # OR
M 17 09   # OUT 1
M 18 70   # XOR gives zero
M 19 0A   # OUT 2
M 1A 10   # LDI A 20
M 1B 20
M 1C 11   # LDI B 30
M 1D 30
M 1E 06   # CMP with A below B
M 1F 19   # JZ not taken
M 20 22
M 21 0B   # OUT 3
M 22 1B   # JC taken
M 23 25
M 24 0C   # OUT 4 skipped
M 25 1C   # JNC not taken
M 26 28
M 27 0D   # OUT 5
M 28 1A   # JNZ taken
M 29 2B
M 2A 0E   # OUT 6 skipped
M 2B 11   # LDI B 20
M 2C 20
M 2D 06   # CMP with A equal B
M 2E 19   # JZ taken
M 2F 31
M 30 0F   # OUT 7 skipped
M 31 1A   # JNZ not taken
M 32 34
M 33 08   # OUT 0
M 34 1B   # JC not taken
M 35 37
M 36 09   # OUT 1
M 37 1C   # JNC taken
M 38 3A
M 39 0A   # OUT 2 skipped
M 3A 18   # JMP
M 3B 3D
M 3C 0B   # OUT 3 skipped
M 3D 0C   # OUT 4
M 3E 05   # HLT
O 1 3C
O 2 99
O 3 5E
O 4 24
O 5 25
O 6 24
O 7 5F
O 0 45
O 1 C5
O 2 00
O 3 20
O 5 20
O 0 20
O 1 20
O 4 20
